//--- dv/cp0_chk.sv
`timescale 1ns/1ps

module cp0_chk import mips_pkg::*, cp0_pkg::*; (
    input logic  clk,
    input logic  reset,
    input logic  exc_valid,
    input logic  is_eret,
    input logic  redirect_valid,
    input logic  int_pending,
    input word_t status
);

    // read by the testbench summary
    int fails = 0;

    a_single: assert property (@(posedge clk) disable iff (reset)
        redirect_valid |=> !redirect_valid)
        else begin
            $error("redirect_valid high for two cycles in a row");
            fails++;
        end

    a_follow: assert property (@(posedge clk) disable iff (reset)
        (exc_valid || is_eret) |=> redirect_valid)
        else begin
            $error("no redirect after exception or eret");
            fails++;
        end

    a_source: assert property (@(posedge clk) disable iff (reset)
        redirect_valid |-> $past(exc_valid || is_eret))
        else begin
            $error("redirect without exception or eret");
            fails++;
        end

    // kernel levels mask all interrupts
    a_masked: assert property (@(posedge clk) disable iff (reset)
        $rose(int_pending) |-> (!status[st_exl] && !status[st_erl]))
        else begin
            $error("int_pending rose while EXL or ERL set");
            fails++;
        end

endmodule

//--- dv/cp0_tb.sv
`timescale 1ns/1ps

module cp0_tb import mips_pkg::*, cp0_pkg::*; ();

    localparam word_t      vec     = 32'hbfc0_0380;
    localparam int         tdiv    = 2;
    localparam int         cmp_val = 6;
    localparam creg_addr_t no_reg  = 5'd0;

    localparam int op_wr   = 0;
    localparam int op_rd   = 1;
    localparam int op_exc  = 2;
    localparam int op_eret = 3;
    localparam int op_rdr  = 4;
    localparam int op_tmr  = 5;
    localparam int op_int  = 6;
    localparam int op_wait = 7;

    // exc rows: addr is the code, data the pc, aux the bad address
    // wr rows on port 2: data to port 0, aux to port 1
    // int rows: exp holds {level raised, ie, im}, data the software IP bits
    typedef struct {
        int         grp;
        int         op;
        int         port;
        creg_addr_t addr;
        word_t      data;
        int         dslot;
        word_t      aux;
        word_t      exp;
    } row_t;

    logic       clk;
    logic       reset;
    logic       cwr0_en;
    creg_addr_t cwr0_addr;
    word_t      cwr0_data;
    logic       cwr1_en;
    creg_addr_t cwr1_addr;
    word_t      cwr1_data;
    creg_addr_t ra0;
    creg_addr_t ra1;
    word_t      rd0;
    word_t      rd1;
    logic       exc_valid;
    exc_code_t  exc_code;
    word_t      exc_pc;
    logic       exc_in_delay_slot;
    word_t      exc_badvaddr;
    logic       is_eret;
    logic [5:0] hw_int;
    word_t      status;
    word_t      cause;
    word_t      epc;
    logic       int_pending;
    logic       timer_interrupt;
    logic       redirect_valid;
    word_t      redirect_pc;

    row_t        rows[$];
    string       grp_name[1:5];
    logic [31:0] seed;
    int          n_checks = 0;
    int          n_errors = 0;
    int          cycles = 0;
    int          limit = 1000;

    cp0_top #(
        .exc_vector (vec),
        .timer_div  (tdiv)
    ) u_cp0_top (
        .clk               (clk),
        .reset             (reset),
        .cwr0_en           (cwr0_en),
        .cwr0_addr         (cwr0_addr),
        .cwr0_data         (cwr0_data),
        .cwr1_en           (cwr1_en),
        .cwr1_addr         (cwr1_addr),
        .cwr1_data         (cwr1_data),
        .ra0               (ra0),
        .ra1               (ra1),
        .rd0               (rd0),
        .rd1               (rd1),
        .exc_valid         (exc_valid),
        .exc_code          (exc_code),
        .exc_pc            (exc_pc),
        .exc_in_delay_slot (exc_in_delay_slot),
        .exc_badvaddr      (exc_badvaddr),
        .is_eret           (is_eret),
        .hw_int            (hw_int),
        .status            (status),
        .cause             (cause),
        .epc               (epc),
        .int_pending       (int_pending),
        .timer_interrupt   (timer_interrupt),
        .redirect_valid    (redirect_valid),
        .redirect_pc       (redirect_pc)
    );

    bind cp0_top cp0_chk u_chk (
        .clk            (clk),
        .reset          (reset),
        .exc_valid      (exc_valid),
        .is_eret        (is_eret),
        .redirect_valid (redirect_valid),
        .int_pending    (int_pending),
        .status         (status)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // timer stays clear in the interrupt rows, so IP7 is hw_int[5] alone
    function automatic logic int_model(input word_t m, input logic [5:0] hw, input logic [1:0] sw);
        logic [7:0] ip;
        ip = {hw, sw};
        return m[8] && !m[9] && (|(ip & m[7:0]));
    endfunction

    task automatic check_val(input string name, input word_t got, input word_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("** Error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic add_row(input int grp, input int op, input int port, input creg_addr_t addr,
                           input word_t data, input int dslot, input word_t aux,
                           input word_t exp);
        row_t r;
        r.grp   = grp;
        r.op    = op;
        r.port  = port;
        r.addr  = addr;
        r.data  = data;
        r.dslot = dslot;
        r.aux   = aux;
        r.exp   = exp;
        rows.push_back(r);
    endtask

    task automatic drive_idle();
        cwr0_en           = 1'b0;
        cwr0_addr         = '0;
        cwr0_data         = '0;
        cwr1_en           = 1'b0;
        cwr1_addr         = '0;
        cwr1_data         = '0;
        ra0               = '0;
        ra1               = '0;
        exc_valid         = 1'b0;
        exc_code          = '0;
        exc_pc            = '0;
        exc_in_delay_slot = 1'b0;
        exc_badvaddr      = '0;
        is_eret           = 1'b0;
        hw_int            = '0;
    endtask

    task automatic apply_row(input row_t r);
        case (r.op)
            op_wr: begin
                if (r.port != 1) begin
                    cwr0_en   = 1'b1;
                    cwr0_addr = r.addr;
                    cwr0_data = r.data;
                end
                if (r.port != 0) begin
                    cwr1_en   = 1'b1;
                    cwr1_addr = r.addr;
                    cwr1_data = (r.port == 2) ? r.aux : r.data;
                end
            end
            op_rd: begin
                ra0 = r.addr;
                ra1 = r.addr;
            end
            op_exc: begin
                exc_valid         = 1'b1;
                exc_code          = r.addr;
                exc_pc            = r.data;
                exc_in_delay_slot = (r.dslot != 0);
                exc_badvaddr      = r.aux;
            end
            op_eret: is_eret = 1'b1;
            op_int: begin
                seed   = lcg_next(seed);
                hw_int = seed[21:16];
            end
            default: ;
        endcase
    endtask

    task automatic check_row(input row_t r);
        case (r.op)
            op_rd: begin
                check_val($sformatf("rd0[%0d]", r.addr), rd0, r.exp);
                check_val($sformatf("rd1[%0d]", r.addr), rd1, r.exp);
                // status, cause and epc are also top-level outputs
                if (r.addr == reg_status) begin
                    check_val("status", status, r.exp);
                end
                if (r.addr == reg_cause) begin
                    check_val("cause", cause, r.exp);
                end
                if (r.addr == reg_epc) begin
                    check_val("epc", epc, r.exp);
                end
            end
            op_rdr: begin
                check_val("redirect_valid", {31'd0, redirect_valid}, 32'd1);
                check_val("redirect_pc", redirect_pc, r.exp);
            end
            op_tmr: check_val("timer_interrupt", {31'd0, timer_interrupt}, r.exp);
            op_int: check_val("int_pending", {31'd0, int_pending},
                              {31'd0, int_model(r.exp, hw_int, r.data[1:0])});
            default: ;
        endcase
    endtask

    task automatic build_table();
        add_row(1, op_rd, 0, reg_status, 0, 0, 0, status_init);
        add_row(1, op_rd, 0, reg_config, 0, 0, 0, config_init);
        add_row(1, op_rd, 0, reg_compare, 0, 0, 0, 32'h0);
        add_row(1, op_rd, 0, reg_epc, 0, 0, 0, 32'h0);
        add_row(1, op_rd, 0, 5'd3, 0, 0, 0, 32'h0);
        add_row(1, op_rd, 0, 5'd31, 0, 0, 0, 32'h0);
        add_row(1, op_wr, 0, reg_epc, 32'h1234_5678, 0, 0, 0);
        add_row(1, op_rd, 0, reg_epc, 0, 0, 0, 32'h1234_5678);
        add_row(1, op_wr, 1, reg_compare, 32'h0000_0abc, 0, 0, 0);
        add_row(1, op_rd, 0, reg_compare, 0, 0, 0, 32'h0000_0abc);
        // only IE and IM land, EXL written as zero
        add_row(1, op_wr, 0, reg_status, 32'hffff_fffd, 0, 0, 0);
        add_row(1, op_rd, 0, reg_status, 0, 0, 0, 32'h0040_ff05);
        add_row(1, op_wr, 1, reg_cause, 32'hffff_ffff, 0, 0, 0);
        add_row(1, op_rd, 0, reg_cause, 0, 0, 0, 32'h0000_0300);
        add_row(1, op_wr, 2, reg_epc, 32'haaaa_0000, 0, 32'h5555_0000, 0);
        add_row(1, op_rd, 0, reg_epc, 0, 0, 0, 32'haaaa_0000);
        add_row(1, op_wr, 2, reg_cause, 32'h0, 0, 32'h0000_0300, 0);
        add_row(1, op_rd, 0, reg_cause, 0, 0, 0, 32'h0);

        add_row(2, op_wr, 0, reg_count, 32'h0000_0100, 0, 0, 0);
        add_row(2, op_rd, 0, reg_count, 0, 0, 0, 32'h0000_0100);
        add_row(2, op_wr, 1, reg_count, 0, 0, 0, 0);
        add_row(2, op_wait, 0, no_reg, 10, 0, 0, 0);
        add_row(2, op_rd, 0, reg_count, 0, 0, 0, 10 / tdiv);
        add_row(2, op_wr, 0, reg_count, 0, 0, 0, 0);
        add_row(2, op_wr, 0, reg_compare, cmp_val, 0, 0, 0);
        add_row(2, op_wait, 0, no_reg, cmp_val * tdiv - 2, 0, 0, 0);
        add_row(2, op_tmr, 0, no_reg, 0, 0, 0, 0);
        add_row(2, op_rd, 0, reg_count, 0, 0, 0, cmp_val);
        add_row(2, op_tmr, 0, no_reg, 0, 0, 0, 1);
        add_row(2, op_rd, 0, reg_cause, 0, 0, 0, 32'h0000_8000);
        add_row(2, op_wait, 0, no_reg, 5, 0, 0, 0);
        add_row(2, op_tmr, 0, no_reg, 0, 0, 0, 1);
        add_row(2, op_wr, 1, reg_compare, 32'hffff_0000, 0, 0, 0);
        add_row(2, op_tmr, 0, no_reg, 0, 0, 0, 0);
        add_row(2, op_rd, 0, reg_cause, 0, 0, 0, 32'h0);

        add_row(3, op_exc, 0, code_sys, 32'h8000_1000, 0, 32'hdead_beef, 0);
        add_row(3, op_rdr, 0, no_reg, 0, 0, 0, vec);
        add_row(3, op_rd, 0, reg_epc, 0, 0, 0, 32'h8000_1000);
        add_row(3, op_rd, 0, reg_cause, 0, 0, 0, 32'h0000_0020);
        add_row(3, op_rd, 0, reg_status, 0, 0, 0, 32'h0040_ff07);
        add_row(3, op_rd, 0, reg_badvaddr, 0, 0, 0, 32'h0);
        // nested, EPC and BD stay
        add_row(3, op_exc, 0, code_adel, 32'h8000_2000, 1, 32'h0000_1001, 0);
        add_row(3, op_rdr, 0, no_reg, 0, 0, 0, vec);
        add_row(3, op_rd, 0, reg_epc, 0, 0, 0, 32'h8000_1000);
        add_row(3, op_rd, 0, reg_badvaddr, 0, 0, 0, 32'h0000_1001);
        add_row(3, op_rd, 0, reg_cause, 0, 0, 0, 32'h0000_0010);

        add_row(4, op_eret, 0, no_reg, 0, 0, 0, 0);
        add_row(4, op_rdr, 0, no_reg, 0, 0, 0, 32'h8000_1000);
        add_row(4, op_rd, 0, reg_status, 0, 0, 0, 32'h0040_ff03);
        add_row(4, op_wr, 0, reg_epc, 32'h8000_3000, 0, 0, 0);
        add_row(4, op_eret, 0, no_reg, 0, 0, 0, 0);
        add_row(4, op_rdr, 0, no_reg, 0, 0, 0, 32'h8000_3000);
        add_row(4, op_rd, 0, reg_status, 0, 0, 0, 32'h0040_ff01);
        add_row(4, op_exc, 0, code_ades, 32'h8000_4004, 1, 32'h0000_2002, 0);
        add_row(4, op_rdr, 0, no_reg, 0, 0, 0, vec);
        add_row(4, op_rd, 0, reg_epc, 0, 0, 0, 32'h8000_4000);
        add_row(4, op_rd, 0, reg_cause, 0, 0, 0, 32'h8000_0014);
        add_row(4, op_rd, 0, reg_badvaddr, 0, 0, 0, 32'h0000_2002);
        add_row(4, op_eret, 0, no_reg, 0, 0, 0, 0);
        add_row(4, op_rdr, 0, no_reg, 0, 0, 0, 32'h8000_4000);
        add_row(4, op_rd, 0, reg_status, 0, 0, 0, 32'h0040_ff01);

        repeat (4) add_row(5, op_int, 0, no_reg, 0, 0, 0, 32'h0000_01ff);
        add_row(5, op_wr, 0, reg_status, 32'h0000_0d01, 0, 0, 0);
        repeat (4) add_row(5, op_int, 0, no_reg, 0, 0, 0, 32'h0000_010d);
        add_row(5, op_wr, 1, reg_cause, 32'h0000_0100, 0, 0, 0);
        repeat (2) add_row(5, op_int, 0, no_reg, 1, 0, 0, 32'h0000_010d);
        add_row(5, op_wr, 1, reg_cause, 32'h0, 0, 0, 0);
        add_row(5, op_wr, 0, reg_status, 32'h0000_ff00, 0, 0, 0);
        repeat (2) add_row(5, op_int, 0, no_reg, 0, 0, 0, 32'h0000_00ff);
        // software sets EXL, then clears it
        add_row(5, op_wr, 0, reg_status, 32'h0000_ff03, 0, 0, 0);
        repeat (2) add_row(5, op_int, 0, no_reg, 0, 0, 0, 32'h0000_03ff);
        add_row(5, op_wr, 0, reg_status, 32'h0000_ff01, 0, 0, 0);
        repeat (3) add_row(5, op_int, 0, no_reg, 0, 0, 0, 32'h0000_01ff);
    endtask

    initial begin
        int total;
        int grp_base;
        clk   = 1'b0;
        reset = 1'b1;
        seed  = 32'h30f8_4e0f;
        drive_idle();
        grp_name[1] = "reset and read/write";
        grp_name[2] = "timer";
        grp_name[3] = "exception recording";
        grp_name[4] = "eret and delay slot";
        grp_name[5] = "interrupt pending";
        build_table();
        total = 3;
        foreach (rows[i]) begin
            total += (rows[i].op == op_wait) ? int'(rows[i].data) : 1;
        end
        limit = 2 * total + 20;

        repeat (3) @(posedge clk);
        #1 reset = 1'b0;

        grp_base = 0;
        foreach (rows[i]) begin
            if (rows[i].op == op_wait) begin
                repeat (rows[i].data) begin
                    @(posedge clk);
                    #1 drive_idle();
                end
            end else begin
                @(posedge clk);
                #1 drive_idle();
                apply_row(rows[i]);
                #2 check_row(rows[i]);
            end
            if (i == rows.size() - 1 || rows[i + 1].grp != rows[i].grp) begin
                $display("group %0d %s: %0d errors", rows[i].grp, grp_name[rows[i].grp],
                         n_errors - grp_base);
                grp_base = n_errors;
            end
        end

        @(posedge clk);
        n_errors += u_cp0_top.u_chk.fails;
        $display("checks %0d, errors %0d, assertion failures %0d", n_checks, n_errors,
                 u_cp0_top.u_chk.fails);
        if (n_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- hdl/cp0_exc_ctrl.sv
`timescale 1ns/1ps

module cp0_exc_ctrl import mips_pkg::*, cp0_pkg::*; #(
    parameter word_t exc_vector = 32'hbfc0_0380
) (
    input  logic       clk,
    input  logic       reset,
    exc_if.ctrl        exc,
    input  logic       is_eret,
    input  word_t      epc,
    input  logic       exl_wr,
    input  logic       exl_wd,
    input  logic       ie,
    input  logic [7:0] im,
    input  logic [7:0] ip,
    output logic       exc_commit,
    output logic       epc_capture,
    output logic       exl,
    output logic       erl,
    output logic       int_pending,
    output logic       redirect_valid,
    output word_t      redirect_pc
);

    level_t lvl;
    level_t lvl_next;

    assign exl = (lvl == lvl_exc) || (lvl == lvl_err_exc);
    assign erl = (lvl == lvl_err) || (lvl == lvl_err_exc);

    assign exc_commit = exc.valid;
    // nested exception keeps the first EPC
    assign epc_capture = exc.valid && !exl;

    assign int_pending = ie && !exl && !erl && |(ip & im);

    // exception beats eret, eret beats a status write
    always_comb begin
        lvl_next = lvl;
        if (exc.valid) begin
            lvl_next = erl ? lvl_err_exc : lvl_exc;
        end else if (is_eret) begin
            case (lvl)
                lvl_err_exc: lvl_next = lvl_exc;
                default:     lvl_next = lvl_normal;
            endcase
        end else if (exl_wr) begin
            if (erl) begin
                lvl_next = exl_wd ? lvl_err_exc : lvl_err;
            end else begin
                lvl_next = exl_wd ? lvl_exc : lvl_normal;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lvl <= lvl_err;
        end else begin
            lvl <= lvl_next;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            redirect_valid <= 1'b0;
        end else begin
            redirect_valid <= exc.valid || is_eret;
        end
    end

    // eret returns to the EPC held before this edge
    always_ff @(posedge clk) begin
        if (exc.valid) begin
            redirect_pc <= exc_vector;
        end else if (is_eret) begin
            redirect_pc <= epc;
        end
    end

endmodule

//--- hdl/cp0_pkg.sv
package cp0_pkg;

    import mips_pkg::*;

    // register numbers, select 0 only
    localparam creg_addr_t reg_badvaddr = 5'd8;
    localparam creg_addr_t reg_count    = 5'd9;
    localparam creg_addr_t reg_compare  = 5'd11;
    localparam creg_addr_t reg_status   = 5'd12;
    localparam creg_addr_t reg_cause    = 5'd13;
    localparam creg_addr_t reg_epc      = 5'd14;
    localparam creg_addr_t reg_config   = 5'd16;

    // status fields
    localparam int st_ie    = 0;
    localparam int st_exl   = 1;
    localparam int st_erl   = 2;
    localparam int st_im_lo = 8;
    localparam int st_im_hi = 15;

    // cause fields
    localparam int ca_exc_lo = 2;
    localparam int ca_exc_hi = 6;
    localparam int ca_ip_lo  = 8;
    localparam int ca_ip_hi  = 15;
    localparam int ca_bd     = 31;

    // BEV and ERL set out of reset
    localparam word_t status_init = 32'h0040_0004;
    // M bit set, kseg0 uncached
    localparam word_t config_init = 32'h8000_0002;

    // ERL/EXL combinations
    typedef enum logic [1:0] {
        lvl_normal,
        lvl_exc,
        lvl_err,
        lvl_err_exc
    } level_t;

endpackage

//--- hdl/cp0_regs.sv
`timescale 1ns/1ps

module cp0_regs import mips_pkg::*, cp0_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       cwr0_en,
    input  logic       cwr1_en,
    input  creg_addr_t cwr0_addr,
    input  creg_addr_t cwr1_addr,
    input  word_t      cwr0_data,
    input  word_t      cwr1_data,
    input  creg_addr_t ra0,
    input  creg_addr_t ra1,
    output word_t      rd0,
    output word_t      rd1,
    exc_if.regs        exc,
    input  logic       exc_commit,
    input  logic       epc_capture,
    input  logic       exl,
    input  logic       erl,
    input  word_t      count,
    input  word_t      compare,
    input  logic       timer_irq,
    input  logic [5:0] hw_int,
    output logic       count_wr,
    output logic       compare_wr,
    output word_t      wr_data,
    output logic       exl_wr,
    output logic       exl_wd,
    output logic       ie,
    output logic [7:0] im,
    output logic [7:0] ip,
    output word_t      status,
    output word_t      cause,
    output word_t      epc
);

    logic       status_we;
    logic       cause_we;
    logic       epc_we;
    word_t      status_wd;
    word_t      cause_wd;
    word_t      epc_wd;
    logic [1:0] ip_sw;
    exc_code_t  exccode;
    logic       bd;
    word_t      badvaddr;

    // port 1 first so that port 0 overrides it
    always_comb begin
        status_we = 1'b0;
        cause_we  = 1'b0;
        epc_we    = 1'b0;
        status_wd = cwr1_data;
        cause_wd  = cwr1_data;
        epc_wd    = cwr1_data;
        if (cwr1_en) begin
            status_we = (cwr1_addr == reg_status);
            cause_we  = (cwr1_addr == reg_cause);
            epc_we    = (cwr1_addr == reg_epc);
        end
        if (cwr0_en && cwr0_addr == reg_status) begin
            status_we = 1'b1;
            status_wd = cwr0_data;
        end
        if (cwr0_en && cwr0_addr == reg_cause) begin
            cause_we = 1'b1;
            cause_wd = cwr0_data;
        end
        if (cwr0_en && cwr0_addr == reg_epc) begin
            epc_we = 1'b1;
            epc_wd = cwr0_data;
        end
    end

    // timer registers share one data path
    always_comb begin
        count_wr   = (cwr0_en && cwr0_addr == reg_count) ||
                     (cwr1_en && cwr1_addr == reg_count);
        compare_wr = (cwr0_en && cwr0_addr == reg_compare) ||
                     (cwr1_en && cwr1_addr == reg_compare);
        if (cwr0_en && (cwr0_addr == reg_count || cwr0_addr == reg_compare)) begin
            wr_data = cwr0_data;
        end else begin
            wr_data = cwr1_data;
        end
    end

    assign exl_wr = status_we;
    assign exl_wd = status_wd[st_exl];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ie       <= status_init[st_ie];
            im       <= status_init[st_im_hi:st_im_lo];
            ip_sw    <= '0;
            exccode  <= '0;
            bd       <= 1'b0;
            epc      <= '0;
            badvaddr <= '0;
        end else begin
            if (status_we) begin
                ie <= status_wd[st_ie];
                im <= status_wd[st_im_hi:st_im_lo];
            end
            if (cause_we) begin
                ip_sw <= cause_wd[ca_ip_lo+1:ca_ip_lo];
            end
            if (epc_we) begin
                epc <= epc_wd;
            end
            if (exc_commit) begin
                exccode <= exc.code;
                if (exc.code == code_adel || exc.code == code_ades) begin
                    badvaddr <= exc.badvaddr;
                end
            end
            // exception capture overrides a software EPC write
            if (epc_capture) begin
                bd  <= exc.in_delay_slot;
                epc <= exc.in_delay_slot ? exc.pc - 32'd4 : exc.pc;
            end
        end
    end

    // IP7 is shared by hw_int[5] and the timer
    assign ip = {hw_int[5] | timer_irq, hw_int[4:0], ip_sw};

    always_comb begin
        status = status_init;
        status[st_im_hi:st_im_lo] = im;
        status[st_erl] = erl;
        status[st_exl] = exl;
        status[st_ie]  = ie;
    end

    always_comb begin
        cause = '0;
        cause[ca_bd] = bd;
        cause[ca_ip_hi:ca_ip_lo] = ip;
        cause[ca_exc_hi:ca_exc_lo] = exccode;
    end

    function automatic word_t read_reg(creg_addr_t addr);
        word_t v;
        case (addr)
            reg_badvaddr: v = badvaddr;
            reg_count:    v = count;
            reg_compare:  v = compare;
            reg_status:   v = status;
            reg_cause:    v = cause;
            reg_epc:      v = epc;
            reg_config:   v = config_init;
            default:      v = '0;
        endcase
        return v;
    endfunction

    always_comb begin
        rd0 = read_reg(ra0);
        rd1 = read_reg(ra1);
    end

endmodule

//--- hdl/cp0_timer.sv
`timescale 1ns/1ps

module cp0_timer import mips_pkg::*; #(
    parameter int timer_div = 2
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  count_wr,
    input  logic  compare_wr,
    input  word_t wr_data,
    output word_t count,
    output word_t compare,
    output logic  timer_irq
);

    localparam int pre_w = (timer_div > 1) ? $clog2(timer_div) : 1;
    localparam logic [pre_w-1:0] pre_last = pre_w'(timer_div - 1);

    logic [pre_w-1:0] pre;
    logic             tick;
    logic             match;
    logic             match_d;

    assign tick  = (pre == pre_last);
    assign match = (count == compare);

    // count write restarts the prescaler
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pre   <= '0;
            count <= '0;
        end else if (count_wr) begin
            pre   <= '0;
            count <= wr_data;
        end else if (tick) begin
            pre   <= '0;
            count <= count + 32'd1;
        end else begin
            pre <= pre + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            compare <= '0;
        end else if (compare_wr) begin
            compare <= wr_data;
        end
    end

    // fire only when equality is reached, not on the reset state 0 == 0
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            match_d   <= 1'b1;
            timer_irq <= 1'b0;
        end else begin
            match_d <= match;
            if (compare_wr) begin
                timer_irq <= 1'b0;
            end else if (match && !match_d) begin
                timer_irq <= 1'b1;
            end
        end
    end

endmodule

//--- hdl/cp0_top.sv
`timescale 1ns/1ps

module cp0_top import mips_pkg::*; #(
    parameter word_t exc_vector = 32'hbfc0_0380,
    parameter int    timer_div  = 2
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       cwr0_en,
    input  creg_addr_t cwr0_addr,
    input  word_t      cwr0_data,
    input  logic       cwr1_en,
    input  creg_addr_t cwr1_addr,
    input  word_t      cwr1_data,
    input  creg_addr_t ra0,
    input  creg_addr_t ra1,
    output word_t      rd0,
    output word_t      rd1,
    input  logic       exc_valid,
    input  exc_code_t  exc_code,
    input  word_t      exc_pc,
    input  logic       exc_in_delay_slot,
    input  word_t      exc_badvaddr,
    input  logic       is_eret,
    input  logic [5:0] hw_int,
    output word_t      status,
    output word_t      cause,
    output word_t      epc,
    output logic       int_pending,
    output logic       timer_interrupt,
    output logic       redirect_valid,
    output word_t      redirect_pc
);

    exc_if u_exc ();

    logic       exc_commit;
    logic       epc_capture;
    logic       exl;
    logic       erl;
    logic       exl_wr;
    logic       exl_wd;
    logic       ie;
    logic [7:0] im;
    logic [7:0] ip;
    logic       count_wr;
    logic       compare_wr;
    word_t      wr_data;
    word_t      count;
    word_t      compare;

    assign u_exc.valid         = exc_valid;
    assign u_exc.code          = exc_code;
    assign u_exc.pc            = exc_pc;
    assign u_exc.in_delay_slot = exc_in_delay_slot;
    assign u_exc.badvaddr      = exc_badvaddr;

    cp0_exc_ctrl #(
        .exc_vector (exc_vector)
    ) u_exc_ctrl (
        .clk            (clk),
        .reset          (reset),
        .exc            (u_exc.ctrl),
        .is_eret        (is_eret),
        .epc            (epc),
        .exl_wr         (exl_wr),
        .exl_wd         (exl_wd),
        .ie             (ie),
        .im             (im),
        .ip             (ip),
        .exc_commit     (exc_commit),
        .epc_capture    (epc_capture),
        .exl            (exl),
        .erl            (erl),
        .int_pending    (int_pending),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    cp0_timer #(
        .timer_div (timer_div)
    ) u_timer (
        .clk        (clk),
        .reset      (reset),
        .count_wr   (count_wr),
        .compare_wr (compare_wr),
        .wr_data    (wr_data),
        .count      (count),
        .compare    (compare),
        .timer_irq  (timer_interrupt)
    );

    cp0_regs u_regs (
        .clk         (clk),
        .reset       (reset),
        .cwr0_en     (cwr0_en),
        .cwr1_en     (cwr1_en),
        .cwr0_addr   (cwr0_addr),
        .cwr1_addr   (cwr1_addr),
        .cwr0_data   (cwr0_data),
        .cwr1_data   (cwr1_data),
        .ra0         (ra0),
        .ra1         (ra1),
        .rd0         (rd0),
        .rd1         (rd1),
        .exc         (u_exc.regs),
        .exc_commit  (exc_commit),
        .epc_capture (epc_capture),
        .exl         (exl),
        .erl         (erl),
        .count       (count),
        .compare     (compare),
        .timer_irq   (timer_interrupt),
        .hw_int      (hw_int),
        .count_wr    (count_wr),
        .compare_wr  (compare_wr),
        .wr_data     (wr_data),
        .exl_wr      (exl_wr),
        .exl_wd      (exl_wd),
        .ie          (ie),
        .im          (im),
        .ip          (ip),
        .status      (status),
        .cause       (cause),
        .epc         (epc)
    );

endmodule

//--- hdl/exc_if.sv
`timescale 1ns/1ps

interface exc_if import mips_pkg::*; ();

    logic      valid;
    exc_code_t code;
    word_t     pc;
    logic      in_delay_slot;
    word_t     badvaddr;

    modport src (output valid, code, pc, in_delay_slot, badvaddr);

    modport ctrl (input valid);

    // the control block decides whether anything is recorded
    modport regs (input code, pc, in_delay_slot, badvaddr);

endinterface

//--- hdl/mips_pkg.sv
package mips_pkg;

    // core-wide widths
    typedef logic [31:0] word_t;
    typedef logic [4:0]  creg_addr_t;
    typedef logic [4:0]  exc_code_t;

    // exception codes as written into Cause.ExcCode
    localparam exc_code_t code_int  = 5'h00;
    localparam exc_code_t code_adel = 5'h04;
    localparam exc_code_t code_ades = 5'h05;
    localparam exc_code_t code_sys  = 5'h08;
    localparam exc_code_t code_ov   = 5'h0c;

endpackage

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sources.f --top-module cp0_tb -o cp0_sim

./obj_dir/cp0_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -qx "ALL CHECKS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- sources.f
hdl/mips_pkg.sv
hdl/cp0_pkg.sv
hdl/exc_if.sv
hdl/cp0_exc_ctrl.sv
hdl/cp0_timer.sv
hdl/cp0_regs.sv
hdl/cp0_top.sv
dv/cp0_chk.sv
dv/cp0_tb.sv
